/* verilog/eeprom_cfg.svh */
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// 2 KB part, block bits ride in the control byte
`define EEPROM_ADDR_W 11

`define EEPROM_DATA_W 8

`define EEPROM_DEV_CODE 4'b1010 // type code for serial eeproms

`endif

/* verilog/i2c_bus_pkg.sv */
package i2c_bus_pkg;

    // what the transmitter does during one bit slot
    typedef enum logic [1:0]
    {
        OP_START   = 2'd0,
        OP_STOP    = 2'd1,
        OP_BIT     = 2'd2, // drive slot_bit
        OP_RELEASE = 2'd3  // slave owns sda
    } slot_op_t;

    // scl low in PH_0/PH_1, high in PH_2/PH_3
    typedef enum logic [1:0]
    {
        PH_0 = 2'd0,
        PH_1 = 2'd1,
        PH_2 = 2'd2,
        PH_3 = 2'd3
    } slot_phase_t;

endpackage

/* verilog/eeprom_cmd_pkg.sv */
`include "eeprom_cfg.svh"

package eeprom_cmd_pkg;

    typedef enum logic [3:0]
    {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        WDATA,
        RESTART, // repeated start before the read
        CTRL_R,
        RDATA,
        STOP
    } seq_state_t;

    // device code, block bits a10..a8, r/w bit
    function automatic logic [`EEPROM_DATA_W-1:0] ctrl_byte(input logic [2:0] block,
                                                            input logic       rd_bit);
        return {`EEPROM_DEV_CODE, block, rd_bit};
    endfunction

endpackage

/* verilog/i2c_bit_tx.sv */
`timescale 1ns/10ps

module i2c_bit_tx (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     slot_run,
    input  i2c_bus_pkg::slot_op_t    slot_op,
    input  logic                     slot_bit,
    output i2c_bus_pkg::slot_phase_t phase,
    output logic                     slot_end,
    output logic                     scl,
    output logic                     sda_drive_low
);
    import i2c_bus_pkg::*;

    logic scl_high;

    // free running while slots are requested, parked in PH_0 otherwise
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase <= PH_0;
        end
        else if (slot_run)
        begin
            phase <= slot_phase_t'(phase + 2'd1);
        end
        else
        begin
            phase <= PH_0;
        end
    end

    assign slot_end = slot_run && (phase == PH_3); // sequencer loads next op here

    assign scl_high = (phase == PH_2) || (phase == PH_3);

    // bus idles with scl high
    assign scl = !slot_run || scl_high;

    // sda only ever pulled low, pad releases otherwise
    always_comb
    begin
        sda_drive_low = 1'b0;
        if (slot_run)
        begin
            case (slot_op)
                OP_START:
                begin
                    sda_drive_low = (phase == PH_3); // falls while scl high
                end
                OP_STOP:
                begin
                    sda_drive_low = (phase != PH_3); // rises while scl high
                end
                OP_BIT:
                begin
                    sda_drive_low = !slot_bit;
                end
                default:
                begin
                    sda_drive_low = 1'b0;
                end
            endcase
        end
    end

endmodule

/* verilog/i2c_bit_rx.sv */
`timescale 1ns/10ps
`include "eeprom_cfg.svh"

module i2c_bit_rx (
    input  logic                      CLK,
    input  logic                      RESET,
    input  i2c_bus_pkg::slot_phase_t  phase,
    input  i2c_bus_pkg::slot_op_t     slot_op,
    input  logic                      sda_in,
    output logic [`EEPROM_DATA_W-1:0] rx_byte,
    output logic                      rx_bit
);
    import i2c_bus_pkg::*;

    logic sample;

    // middle of the scl high time, only in slots the slave drives
    assign sample = (phase == PH_2) && (slot_op == OP_RELEASE);

    // msb arrives first
    always_ff @(posedge CLK)
    begin
        if (sample)
        begin
            rx_byte <= {rx_byte[`EEPROM_DATA_W-2:0], sda_in};
        end
    end

    // last sampled bit doubles as the ack, 0 = ack
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            rx_bit <= 1'b1;
        end
        else if (sample)
        begin
            rx_bit <= sda_in;
        end
    end

endmodule

/* verilog/eeprom_sequencer.sv */
`timescale 1ns/10ps
`include "eeprom_cfg.svh"

module eeprom_sequencer (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [`EEPROM_DATA_W-1:0] wdata,
    input  logic                      slot_end,
    input  logic [`EEPROM_DATA_W-1:0] rx_byte,
    input  logic                      rx_bit,
    output logic                      slot_run,
    output i2c_bus_pkg::slot_op_t     slot_op,
    output logic                      slot_bit,
    output logic [`EEPROM_DATA_W-1:0] rdata,
    output logic                      done,
    output logic                      nack_err,
    output logic                      busy
);
    import i2c_bus_pkg::*;
    import eeprom_cmd_pkg::*;

    seq_state_t                state;
    seq_state_t                state_nx;
    logic [`EEPROM_ADDR_W-1:0] addr_q;
    logic [`EEPROM_DATA_W-1:0] wdata_q;
    logic [`EEPROM_DATA_W-1:0] tx_sh;
    logic [`EEPROM_DATA_W-1:0] rd_hold;
    logic [`EEPROM_DATA_W-1:0] load_val;
    logic [2:0]                blk;
    logic [3:0]                bit_cnt; // 0..7 data, 8 ack
    logic                      is_read;
    logic                      nack_flag;
    logic                      in_byte;
    logic                      ack_slot;
    logic                      accept;
    logic                      abort;
    logic                      advance;
    logic                      finish;

    assign blk      = addr_q[`EEPROM_ADDR_W-1 -: 3];
    assign in_byte  = state inside {CTRL_W, ADDR, WDATA, CTRL_R, RDATA};
    assign ack_slot = in_byte && (bit_cnt == 4'd8);
    assign accept   = (state == IDLE) && !busy && (wr || rd);
    assign abort    = slot_end && ack_slot && (state != RDATA) && rx_bit; // slave nack
    assign advance  = slot_end && ((state inside {START, RESTART}) || (ack_slot && !abort));
    assign finish   = slot_end && (state == STOP);

    always_comb
    begin
        state_nx = state;
        case (state)
            START:   state_nx = CTRL_W;
            CTRL_W:  state_nx = ADDR;
            ADDR:    state_nx = is_read ? RESTART : WDATA;
            WDATA:   state_nx = STOP;
            RESTART: state_nx = CTRL_R;
            CTRL_R:  state_nx = RDATA;
            RDATA:   state_nx = STOP;
            default: state_nx = state;
        endcase
    end

    // byte sent in the state being entered
    always_comb
    begin
        case (state_nx)
            CTRL_W:  load_val = ctrl_byte(blk, 1'b0);
            ADDR:    load_val = addr_q[`EEPROM_DATA_W-1:0];
            CTRL_R:  load_val = ctrl_byte(blk, 1'b1);
            default: load_val = wdata_q;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            nack_err  <= 1'b0;
            slot_run  <= 1'b0;
            slot_op   <= OP_RELEASE;
            slot_bit  <= 1'b1;
            bit_cnt   <= 4'd0;
            is_read   <= 1'b0;
            nack_flag <= 1'b0;
        end
        else
        begin
            done     <= 1'b0;
            nack_err <= 1'b0;
            if (accept)
            begin
                busy      <= 1'b1;
                is_read   <= !wr; // wr wins
                nack_flag <= 1'b0;
                slot_run  <= 1'b1;
                slot_op   <= OP_START;
                state     <= START;
            end
            else if (state == IDLE)
            begin
                busy <= 1'b0; // one cycle after done
            end
            else if (finish)
            begin
                slot_run <= 1'b0;
                done     <= 1'b1;
                nack_err <= nack_flag;
                state    <= IDLE;
            end
            else if (abort)
            begin
                nack_flag <= 1'b1;
                slot_op   <= OP_STOP;
                state     <= STOP;
            end
            else if (advance)
            begin
                state   <= state_nx;
                bit_cnt <= 4'd0;
                case (state_nx)
                    RESTART: slot_op <= OP_START;
                    RDATA:   slot_op <= OP_RELEASE;
                    STOP:    slot_op <= OP_STOP;
                    default:
                    begin
                        slot_op  <= OP_BIT;
                        slot_bit <= load_val[`EEPROM_DATA_W-1];
                    end
                endcase
            end
            else if (slot_end && in_byte)
            begin
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd7)
                begin
                    if (state == RDATA)
                    begin
                        slot_op  <= OP_BIT; // host nack ends the read
                        slot_bit <= 1'b1;
                    end
                    else
                    begin
                        slot_op <= OP_RELEASE;
                    end
                end
                else
                begin
                    slot_bit <= tx_sh[`EEPROM_DATA_W-1];
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (advance)
        begin
            tx_sh <= load_val << 1; // msb already on slot_bit
        end
        else if (slot_end && in_byte && (bit_cnt < 4'd7))
        begin
            tx_sh <= tx_sh << 1;
        end
        if (slot_end && (state == RDATA) && (bit_cnt == 4'd7))
        begin
            rd_hold <= rx_byte;
        end
        if (finish && is_read && !nack_flag)
        begin
            rdata <= rd_hold;
        end
    end

endmodule

/* verilog/eeprom_ctrl.sv */
`timescale 1ns/10ps
`include "eeprom_cfg.svh"

module eeprom_ctrl (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [`EEPROM_DATA_W-1:0] wdata,
    output logic [`EEPROM_DATA_W-1:0] rdata,
    output logic                      done,
    output logic                      nack_err,
    output logic                      busy,
    output logic                      scl,
    inout  wire                       sda
);
    import i2c_bus_pkg::*;

    slot_op_t                  slot_op;
    slot_phase_t               phase;
    logic                      slot_run;
    logic                      slot_bit;
    logic                      slot_end;
    logic                      sda_drive_low;
    logic                      sda_in;
    logic [`EEPROM_DATA_W-1:0] rx_byte;
    logic                      rx_bit;

    // open drain pad, high level comes from the pull-up
    assign sda    = sda_drive_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

    eeprom_sequencer u_seq (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .slot_end (slot_end),
        .rx_byte  (rx_byte),
        .rx_bit   (rx_bit),
        .slot_run (slot_run),
        .slot_op  (slot_op),
        .slot_bit (slot_bit),
        .rdata    (rdata),
        .done     (done),
        .nack_err (nack_err),
        .busy     (busy)
    );

    i2c_bit_tx u_tx (
        .CLK           (CLK),
        .RESET         (RESET),
        .slot_run      (slot_run),
        .slot_op       (slot_op),
        .slot_bit      (slot_bit),
        .phase         (phase),
        .slot_end      (slot_end),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

    i2c_bit_rx u_rx (
        .CLK     (CLK),
        .RESET   (RESET),
        .phase   (phase),
        .slot_op (slot_op),
        .sda_in  (sda_in),
        .rx_byte (rx_byte),
        .rx_bit  (rx_bit)
    );

endmodule

/* sim/eeprom_model.sv */
`timescale 1ns/10ps
`include "eeprom_cfg.svh"

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic force_nack,
    inout  wire  sda
);
    logic [`EEPROM_DATA_W-1:0] mem [0:(1 << `EEPROM_ADDR_W)-1];
    logic [`EEPROM_ADDR_W-1:0] ptr;
    logic [`EEPROM_DATA_W-1:0] sh;
    logic [`EEPROM_DATA_W-1:0] tx;
    logic [3:0]                cnt; // scl rises in this byte, 9 = ack seen
    logic [1:0]                byte_idx;
    logic [2:0]                blk;
    logic                      scl_q;
    logic                      sda_q;
    logic                      sda_s;
    logic                      active;
    logic                      rd_mode;
    logic                      sending;
    logic                      drive_low;
    logic                      rx_ok;

    pullup (sda);
    assign sda   = drive_low ? 1'b0 : 1'bz;
    assign sda_s = (sda === 1'b0) ? 1'b0 : 1'b1;

    // ack control byte only for our type code, no page writes
    assign rx_ok = !force_nack &&
                   ((byte_idx == 2'd0) ? (sh[7:4] == `EEPROM_DEV_CODE) : (byte_idx != 2'd3));

    initial
    begin
        for (int i = 0; i < (1 << `EEPROM_ADDR_W); i++)
        begin
            mem[i] = i[7:0] ^ 8'hA5 ^ {5'd0, i[10:8]};
        end
    end

    // bus sampled mid cycle, edges found against the previous sample
    always @(negedge CLK)
    begin
        if (RESET)
        begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            active    <= 1'b0;
            rd_mode   <= 1'b0;
            sending   <= 1'b0;
            drive_low <= 1'b0;
            cnt       <= 4'd0;
            byte_idx  <= 2'd0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda_s;
            if (scl_q && scl && sda_q && !sda_s) // start or repeated start
            begin
                active    <= 1'b1;
                sending   <= 1'b0;
                drive_low <= 1'b0;
                cnt       <= 4'd0;
                byte_idx  <= 2'd0;
            end
            else if (scl_q && scl && !sda_q && sda_s) // stop
            begin
                active    <= 1'b0;
                sending   <= 1'b0;
                drive_low <= 1'b0;
            end
            else if (active && !scl_q && scl)
            begin
                if (cnt < 4'd8)
                begin
                    sh  <= {sh[6:0], sda_s};
                    cnt <= cnt + 4'd1;
                end
                else
                begin
                    cnt <= 4'd9;
                end
            end
            else if (active && scl_q && !scl)
            begin
                if ((cnt == 4'd8) && !sending)
                begin
                    drive_low <= rx_ok;
                    active    <= rx_ok; // nacked, wait for next start
                    byte_idx  <= byte_idx + 2'd1;
                    case (byte_idx)
                        2'd0:
                        begin
                            blk     <= sh[3:1];
                            rd_mode <= sh[0];
                        end
                        2'd1:    ptr <= {blk, sh};
                        2'd2:    mem[ptr] <= sh;
                        default: ;
                    endcase
                end
                else if (cnt == 4'd8)
                begin
                    drive_low <= 1'b0; // master acks the read byte
                end
                else if (cnt == 4'd9)
                begin
                    cnt <= 4'd0;
                    if (sending || !rd_mode)
                    begin
                        sending   <= 1'b0;
                        rd_mode   <= 1'b0;
                        drive_low <= 1'b0;
                    end
                    else
                    begin
                        sending   <= 1'b1;
                        tx        <= mem[ptr];
                        drive_low <= !mem[ptr][7];
                    end
                end
                else if (sending)
                begin
                    drive_low <= !tx[7 - cnt];
                end
            end
        end
    end

endmodule

/* sim/eeprom_ctrl_asserts.sv */
`timescale 1ns/10ps

module eeprom_ctrl_asserts (
    input logic CLK,
    input logic RESET,
    input logic wr,
    input logic rd,
    input logic done,
    input logic nack_err,
    input logic busy
);

    done_pulse: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
        else $error("done held longer than one cycle");

    nack_pulse: assert property (@(posedge CLK) disable iff (RESET) nack_err |=> !nack_err)
        else $error("nack_err held longer than one cycle");

    nack_with_done: assert property (@(posedge CLK) disable iff (RESET) nack_err |-> done)
        else $error("nack_err without done");

    // busy from the accepted request up to done
    busy_rise: assert property (@(posedge CLK) disable iff (RESET)
                                !busy && (wr || rd) |=> busy)
        else $error("request while idle did not raise busy");

    busy_hold: assert property (@(posedge CLK) disable iff (RESET) busy && !done |=> busy)
        else $error("busy dropped before done");

endmodule

bind eeprom_sequencer eeprom_ctrl_asserts u_asserts (
    .CLK      (CLK),
    .RESET    (RESET),
    .wr       (wr),
    .rd       (rd),
    .done     (done),
    .nack_err (nack_err),
    .busy     (busy)
);

/* sim/tb_eeprom_ctrl.sv */
`timescale 1ns/10ps
`include "eeprom_cfg.svh"

module tb_eeprom_ctrl;

    logic                      CLK;
    logic                      RESET;
    logic                      wr;
    logic                      rd;
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic [`EEPROM_DATA_W-1:0] wdata;
    logic [`EEPROM_DATA_W-1:0] rdata;
    logic                      done;
    logic                      nack_err;
    logic                      busy;
    logic                      scl;
    logic                      force_nack;
    wire                       sda;

    integer                    fd;
    integer                    code;
    integer                    tests;
    integer                    fails;
    logic                      timed_out;
    logic [63:0]               tok;
    logic [8*100-1:0]          rest;
    logic [`EEPROM_ADDR_W-1:0] t_addr;
    logic [`EEPROM_DATA_W-1:0] t_wdata;
    logic [`EEPROM_DATA_W-1:0] t_rdata;
    logic                      t_nack;
    logic [`EEPROM_DATA_W-1:0] got_rdata;
    logic                      got_nack;
    logic                      busy_at_wr;

    eeprom_ctrl DUT (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .done     (done),
        .nack_err (nack_err),
        .busy     (busy),
        .scl      (scl),
        .sda      (sda)
    );

    eeprom_model u_eeprom (
        .CLK        (CLK),
        .RESET      (RESET),
        .scl        (scl),
        .force_nack (force_nack),
        .sda        (sda)
    );

    always #10 CLK = ~CLK;

    // wait for idle, then hold the request until busy rises
    task automatic request(input logic is_rd, input logic [`EEPROM_ADDR_W-1:0] a,
                           input logic [`EEPROM_DATA_W-1:0] d);
        integer n;
        n = 0;
        while (busy && (n < 2000))
        begin
            @(negedge CLK);
            n = n + 1;
        end
        if (busy)
        begin
            $display("timeout: DUT stayed busy before request at %h", a);
            timed_out = 1'b1;
        end
        @(negedge CLK);
        addr  = a;
        wdata = d;
        rd    = is_rd;
        wr    = !is_rd;
        @(negedge CLK);
        n = 1;
        while (!busy && (n < 2000))
        begin
            @(negedge CLK);
            n = n + 1;
        end
        rd = 1'b0;
        wr = 1'b0;
        if (!busy)
        begin
            $display("timeout: request at %h was never accepted", a);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_done;
        integer n;
        n = 0;
        while (!done && (n < 2000))
        begin
            @(negedge CLK);
            n = n + 1;
        end
        got_rdata = rdata;
        got_nack  = nack_err;
        if (!done)
        begin
            $display("timeout: no done within 2000 cycles");
            timed_out = 1'b1;
        end
    endtask

    task automatic check_result(input logic [7:0] op, input logic chk_data);
        logic ok;
        ok    = 1'b1;
        tests = tests + 1;
        if (got_nack !== t_nack)
        begin
            $display("FAIL test %0d %c@%h nack_err expected %b actual %b",
                     tests, op, t_addr, t_nack, got_nack);
            ok = 1'b0;
        end
        if (chk_data && (got_rdata !== t_rdata))
        begin
            $display("FAIL test %0d %c@%h rdata expected %h actual %h",
                     tests, op, t_addr, t_rdata, got_rdata);
            ok = 1'b0;
        end
        if (busy_at_wr !== 1'b1)
        begin
            $display("FAIL test %0d %c@%h busy at second wr expected 1 actual %b",
                     tests, op, t_addr, busy_at_wr);
            ok = 1'b0;
        end
        if (ok)
            $display("PASS test %0d %c@%h", tests, op, t_addr);
        else
            fails = fails + 1;
    endtask

    task automatic run_op(input logic [7:0] op);
        busy_at_wr = 1'b1;
        if (op == "N")
            force_nack = 1'b1;
        request((op == "R") || (op == "B"), t_addr, t_wdata);
        if ((op == "B") && !timed_out)
        begin
            @(negedge CLK);
            wr    = 1'b1; // should be ignored
            addr  = t_addr + 1'b1;
            wdata = t_wdata;
            busy_at_wr = busy;
            @(negedge CLK);
            wr = 1'b0;
        end
        if (!timed_out)
            wait_done;
        force_nack = 1'b0;
        if (!timed_out)
            check_result(op, (op == "R") || (op == "B"));
    endtask

    initial
    begin
        CLK        = 1'b0;
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = '0;
        force_nack = 1'b0;
        busy_at_wr = 1'b1;
        tests      = 0;
        fails      = 0;
        timed_out  = 1'b0;
        repeat (4) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        tests = tests + 1;
        if ((busy !== 1'b0) || (done !== 1'b0) || (nack_err !== 1'b0) ||
            (scl !== 1'b1) || (sda !== 1'b1))
        begin
            $display("FAIL reset busy,done,nack,scl,sda expected 00011 actual %b%b%b%b%b",
                     busy, done, nack_err, scl, sda);
            fails = fails + 1;
        end
        else
            $display("PASS reset");

        fd = $fopen("sim/eeprom_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file sim/eeprom_trace.txt");
            fails = fails + 1;
        end
        else
        begin
            code = $fscanf(fd, "%s", tok);
            while ((code == 1) && !timed_out)
            begin
                if (tok == "#")
                    code = $fgets(rest, fd);
                else if ((tok != "W") && (tok != "R") && (tok != "N") && (tok != "B"))
                begin
                    $display("unknown operation in trace file, reading stopped");
                    fails = fails + 1;
                    code  = 0;
                end
                else
                begin
                    code = $fscanf(fd, "%h %h %h %h", t_addr, t_wdata, t_rdata, t_nack);
                    if (code != 4)
                    begin
                        $display("malformed line in trace file, reading stopped");
                        fails = fails + 1;
                        code  = 0;
                    end
                    else
                        run_op(tok[7:0]);
                end
                if (code > 0)
                    code = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end

        if (timed_out)
            fails = fails + 1;
        $display("tests run: %0d, failed: %0d", tests, fails);
        if (fails == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* eeprom_ctrl.f */
+incdir+verilog
verilog/i2c_bus_pkg.sv
verilog/eeprom_cmd_pkg.sv
verilog/i2c_bit_tx.sv
verilog/i2c_bit_rx.sv
verilog/eeprom_sequencer.sv
verilog/eeprom_ctrl.sv
sim/eeprom_model.sv
sim/eeprom_ctrl_asserts.sv
sim/tb_eeprom_ctrl.sv

/* Bender.yml */
package:
  name: eeprom_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/i2c_bus_pkg.sv
      - verilog/eeprom_cmd_pkg.sv
      - verilog/i2c_bit_tx.sv
      - verilog/i2c_bit_rx.sv
      - verilog/eeprom_sequencer.sv
      - verilog/eeprom_ctrl.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/eeprom_model.sv
      - sim/eeprom_ctrl_asserts.sv
      - sim/tb_eeprom_ctrl.sv

/* sim/eeprom_trace.txt */
# op addr wdata exp_rdata exp_nack, all hex
# W write, R read, N write with forced nack, B read of addr with a wr to addr+1 while busy
W 010 11 00 0
W 110 22 00 0
W 710 77 00 0
R 010 00 11 0
R 110 00 22 0
R 710 00 77 0
R 210 00 b7 0
R 5ff 00 5f 0
N 123 ee 00 1
R 123 00 87 0
W 123 ee 00 0
R 123 00 ee 0
B 340 99 e6 0
R 341 00 e7 0
